//--- ppfifo_stream.f
src/ppfifo_cfg_pkg.sv
src/ppfifo_block_pkg.sv
src/block_fifo_if.sv
src/axis_to_block_writer.sv
src/ppfifo_buffer.sv
src/block_to_axis_reader.sv
src/ppfifo_stream_top.sv
tb/tb_clock_gen.sv
tb/ppfifo_stream_tb.sv

//--- tb/ppfifo_stream_tb.sv
/*
  Testbench for the stream ping-pong buffer.
  Sends directed and random packets, checks order, last flags, stalls and back-pressure.
*/
module ppfifo_stream_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int DATA_WIDTH = 32;
  localparam int DEPTH      = 16;
  localparam int TIMEOUT    = 5000;

  logic                  clk;
  logic                  rst;
  logic                  i_s_valid;
  logic [DATA_WIDTH-1:0] i_s_data;
  logic                  i_s_last;
  logic                  o_s_ready;
  logic                  o_m_valid;
  logic [DATA_WIDTH-1:0] o_m_data;
  logic                  o_m_last;
  logic                  i_m_ready;

  // Beats still to offer and accepted beats with their expected last flag
  logic [DATA_WIDTH-1:0] pend_data [$];
  logic                  pend_last [$];
  logic [DATA_WIDTH:0]   exp_q [$];

  int          in_count  = 0;
  // Beats since packet start or the previous split
  int          blk_beats = 0;
  logic        gap_en    = 1'b0;
  logic        stall_en  = 1'b0;
  logic        hold_low  = 1'b0;
  logic [31:0] drv_rng;
  logic [31:0] len_rng;
  string       test_name = "reset";

  // Output side as seen on the previous edge
  logic                  was_stalled = 1'b0;
  logic [DATA_WIDTH-1:0] held_data;
  logic                  held_last;

  tb_clock_gen clock_inst (.clk(clk), .rst(rst));

  ppfifo_stream_top #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(DEPTH)) ppfifo_stream_top_inst (
    .clk       (clk),
    .rst       (rst),
    .i_s_valid (i_s_valid),
    .i_s_data  (i_s_data),
    .i_s_last  (i_s_last),
    .o_s_ready (o_s_ready),
    .o_m_valid (o_m_valid),
    .o_m_data  (o_m_data),
    .o_m_last  (o_m_last),
    .i_m_ready (i_m_ready)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic halt_sim();
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic value_error(input string check, input logic [31:0] want,
                             input logic [31:0] got);
    $display("FAILED %s %s expected 0x%0h actual 0x%0h", test_name, check, want, got);
    halt_sim();
  endtask

  task automatic abort_run(input string msg);
    $display("%s: %s", test_name, msg);
    halt_sim();
  endtask

  // Word carries packet number and beat index
  task automatic queue_packet(input int len, input int pkt);
    for (int i = 0; i < len; i++) begin
      pend_data.push_back({16'(pkt), 16'(i)});
      pend_last.push_back(i == len - 1);
    end
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (pend_data.size() != 0 || exp_q.size() != 0) begin
      @(posedge clk);
      n++;
      if (n > TIMEOUT) begin
        abort_run("timed out waiting for the buffer to drain");
      end
    end
  endtask

  // Input stream and output ready driven 1 ns after each edge
  always @(posedge clk) begin
    logic taken;
    taken = !rst && i_s_valid && o_s_ready;
    if (taken) begin
      blk_beats++;
      exp_q.push_back({i_s_last || (blk_beats == DEPTH), i_s_data});
      if (i_s_last || blk_beats == DEPTH) begin
        blk_beats = 0;
      end
      void'(pend_data.pop_front());
      void'(pend_last.pop_front());
      in_count++;
    end
    #1;
    drv_rng = xorshift32(drv_rng);
    // Valid holds until the beat is taken
    if (taken || !i_s_valid) begin
      if (pend_data.size() != 0 && !(gap_en && drv_rng[1:0] == 2'd0)) begin
        i_s_valid = 1'b1;
        i_s_data  = pend_data[0];
        i_s_last  = pend_last[0];
      end else begin
        i_s_valid = 1'b0;
      end
    end
    i_m_ready = !hold_low && !(stall_en && drv_rng[9:8] == 2'd0);
  end

  // Scoreboard and stall stability
  always @(posedge clk) begin
    logic [DATA_WIDTH:0] want;
    if (!rst) begin
      if (was_stalled) begin
        assert (o_m_data == held_data) else value_error("hold_data", held_data, o_m_data);
        assert (o_m_last == held_last) else value_error("hold_last", held_last, o_m_last);
      end
      if (o_m_valid && i_m_ready) begin
        if (exp_q.size() == 0) begin
          abort_run("an output beat arrived with no input beat left to match");
        end else begin
          want = exp_q.pop_front();
          assert (o_m_data == want[DATA_WIDTH-1:0])
            else value_error("data", want[DATA_WIDTH-1:0], o_m_data);
          assert (o_m_last == want[DATA_WIDTH])
            else value_error("last", want[DATA_WIDTH], o_m_last);
        end
      end
      was_stalled = o_m_valid && !i_m_ready;
      held_data   = o_m_data;
      held_last   = o_m_last;
    end
  end

  // A beat offered on the output stays offered until taken
  valid_held: assert property (@(posedge clk) disable iff (rst)
    (o_m_valid && !i_m_ready) |=> o_m_valid)
    else abort_run("o_m_valid dropped while i_m_ready was low");

  initial begin
    int n;
    int base;
    int len;
    int low;
    i_s_valid = 1'b0;
    i_s_data  = '0;
    i_s_last  = 1'b0;
    i_m_ready = 1'b1;
    len_rng   = 32'd53;
    drv_rng   = xorshift32(32'd53);

    // First edge out of reset still shows reset outputs
    n = 0;
    do begin
      @(posedge clk);
      n++;
      if (n > 20) begin
        abort_run("reset was never released");
      end
    end while (rst);
    assert (!o_s_ready) else value_error("o_s_ready", 0, o_s_ready);
    assert (!o_m_valid) else value_error("o_m_valid", 0, o_m_valid);
    repeat (4) begin
      @(posedge clk);
      assert (!o_m_valid) else value_error("o_m_valid", 0, o_m_valid);
    end

    // 1 word, one full bank, and 40 words split 16/16/8
    test_name = "directed";
    queue_packet(1, 1);
    queue_packet(16, 2);
    queue_packet(40, 3);
    wait_drain();

    test_name = "random";
    gap_en    = 1'b1;
    stall_en  = 1'b1;
    for (int p = 0; p < 12; p++) begin
      len_rng = xorshift32(len_rng);
      len     = 1 + int'(len_rng % 40);
      queue_packet(len, 16 + p);
    end
    wait_drain();

    // Writer fills both banks and then finds no empty one
    test_name = "backpressure";
    gap_en    = 1'b0;
    stall_en  = 1'b0;
    hold_low  = 1'b1;
    base      = in_count;
    queue_packet(48, 40);
    n   = 0;
    low = 0;
    while (low < 20) begin
      @(posedge clk);
      low = o_s_ready ? 0 : low + 1;
      n++;
      if (n > TIMEOUT) begin
        abort_run("o_s_ready never stayed low while i_m_ready was held low");
      end
    end
    assert (in_count - base >= 32 && in_count - base <= 34)
      else value_error("accepted", 32, in_count - base);
    hold_low = 1'b0;
    wait_drain();

    // Drained buffer offers no further beat
    test_name = "final";
    repeat (2 * DEPTH) begin
      @(posedge clk);
      assert (!o_m_valid) else value_error("o_m_valid", 0, o_m_valid);
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

//--- tb/tb_clock_gen.sv
/*
  Clock and reset source for the testbench, 4 ns period.
  Reset is held for the first 4 rising edges.
*/
module tb_clock_gen (
  output logic clk,
  output logic rst
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Released just after an edge, like the other inputs
  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
  end

endmodule

//--- src/ppfifo_stream_top.sv
/*
  Stream in, stream out through a two-bank ping-pong buffer.
  Long packets leave as blocks of DEPTH words, each closed with last.
*/
module ppfifo_stream_top #(
  parameter int DATA_WIDTH = ppfifo_cfg_pkg::DATA_WIDTH_DEF,
  parameter int DEPTH      = ppfifo_cfg_pkg::DEPTH_DEF
) (
  input  logic                  clk,
  input  logic                  rst,
  // Input stream
  input  logic                  i_s_valid,
  input  logic [DATA_WIDTH-1:0] i_s_data,
  input  logic                  i_s_last,
  output logic                  o_s_ready,
  // Output stream
  output logic                  o_m_valid,
  output logic [DATA_WIDTH-1:0] o_m_data,
  output logic                  o_m_last,
  input  logic                  i_m_ready
);

  // Write side and read side of the buffer
  block_fifo_if #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(DEPTH)) wr_if ();
  block_fifo_if #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(DEPTH)) rd_if ();

  axis_to_block_writer #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(DEPTH)) writer_inst (
    .clk       (clk),
    .rst       (rst),
    .i_s_valid (i_s_valid),
    .i_s_data  (i_s_data),
    .i_s_last  (i_s_last),
    .o_s_ready (o_s_ready),
    .bus       (wr_if.writer)
  );

  ppfifo_buffer #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(DEPTH)) buffer_inst (
    .clk (clk),
    .rst (rst),
    .wr  (wr_if.wbuf),
    .rd  (rd_if.rbuf)
  );

  block_to_axis_reader #(.DATA_WIDTH(DATA_WIDTH), .DEPTH(DEPTH)) reader_inst (
    .clk       (clk),
    .rst       (rst),
    .bus       (rd_if.reader),
    .o_m_valid (o_m_valid),
    .o_m_data  (o_m_data),
    .o_m_last  (o_m_last),
    .i_m_ready (i_m_ready)
  );

endmodule

//--- src/block_to_axis_reader.sv
/*
  Stream consumer for the ping-pong buffer.
  Reads one full bank at a time and sends it out with last on the final word.
*/
module block_to_axis_reader #(
  parameter int DATA_WIDTH = ppfifo_cfg_pkg::DATA_WIDTH_DEF,
  parameter int DEPTH      = ppfifo_cfg_pkg::DEPTH_DEF
) (
  input  logic                  clk,
  input  logic                  rst,
  block_fifo_if.reader          bus,
  output logic                  o_m_valid,
  output logic [DATA_WIDTH-1:0] o_m_data,
  output logic                  o_m_last,
  input  logic                  i_m_ready
);
  import ppfifo_cfg_pkg::*;

  localparam int CW = count_width(DEPTH);

  // Index of the next word to request
  logic [CW-1:0]         req_idx;
  logic                  last_req;
  // A read returns data next cycle
  logic                  infl;
  logic                  infl_last;

  // Two-entry output queue
  logic [DATA_WIDTH-1:0] q_data [2];
  logic                  q_last [2];
  logic                  q_wp;
  logic                  q_rp;
  logic [1:0]            occ;
  logic                  pop;
  logic [1:0]            load;

  assign last_req = (req_idx == bus.rd_size - 1'b1);

  assign o_m_valid = (occ != 2'd0);
  assign o_m_data  = q_data[q_rp];
  assign o_m_last  = q_last[q_rp];
  assign pop       = o_m_valid && i_m_ready;

  // Queue words plus reads in flight, freed slot counted now for full rate
  assign load       = occ + 2'(infl) - 2'(pop);
  assign bus.rd_stb = bus.rd_act && (load < 2'd2);

  always_ff @(posedge clk) begin
    if (rst) begin
      bus.rd_act <= 1'b0;
      req_idx    <= '0;
      infl       <= 1'b0;
      infl_last  <= 1'b0;
      q_wp       <= 1'b0;
      q_rp       <= 1'b0;
      occ        <= 2'd0;
    end else begin
      infl      <= bus.rd_stb;
      infl_last <= bus.rd_stb && last_req;
      if (!bus.rd_act) begin
        // Claim the bank the buffer presents
        if (bus.rd_rdy) begin
          bus.rd_act <= 1'b1;
          req_idx    <= '0;
        end
      end else if (bus.rd_stb) begin
        req_idx <= req_idx + 1'b1;
        // Last word requested, hand the bank back
        if (last_req) begin
          bus.rd_act <= 1'b0;
        end
      end
      if (infl) begin
        q_wp <= ~q_wp;
      end
      if (pop) begin
        q_rp <= ~q_rp;
      end
      occ <= occ + 2'(infl) - 2'(pop);
    end
  end

  // Returned word lands with its last tag
  always_ff @(posedge clk) begin
    if (infl) begin
      q_data[q_wp] <= bus.rd_data;
      q_last[q_wp] <= infl_last;
    end
  end

endmodule

//--- src/ppfifo_buffer.sv
/*
  Two-bank block memory with per-bank state and word count.
  Banks are handed to the reader in the order they were filled.
*/
module ppfifo_buffer #(
  parameter int DATA_WIDTH = ppfifo_cfg_pkg::DATA_WIDTH_DEF,
  parameter int DEPTH      = ppfifo_cfg_pkg::DEPTH_DEF
) (
  input logic        clk,
  input logic        rst,
  block_fifo_if.wbuf wr,
  block_fifo_if.rbuf rd
);
  import ppfifo_cfg_pkg::*;
  import ppfifo_block_pkg::*;

  localparam int CW = count_width(DEPTH);
  localparam int AW = $clog2(DEPTH);

  // Bank storage
  logic [DATA_WIDTH-1:0] mem [NUM_BANKS][DEPTH];

  bank_state_t   state [NUM_BANKS];
  logic [CW-1:0] count [NUM_BANKS];

  // Bank filled first among the full ones
  logic          oldest;
  // Bank currently being written
  logic          wr_bank;
  logic [CW-1:0] wr_ptr;
  logic [CW-1:0] rd_addr;
  // Zero on the claiming edge so the first strobe reads word 0
  logic [CW-1:0] rd_ptr;
  // Words in the block including a strobe in this cycle
  logic [CW-1:0] wr_fill;

  assign wr_fill = wr_ptr + CW'(wr.wr_stb);
  assign rd_ptr  = (state[oldest] == FULL) ? '0 : rd_addr;

  // Handshake outputs
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      wr.wr_rdy[b] = (state[b] == EMPTY);
    end
    wr.wr_size = CW'(DEPTH);
    // Only the oldest bank is offered so rd_size holds through a read
    rd.rd_rdy  = (state[oldest] == FULL);
    rd.rd_size = count[oldest];
  end

  // Bank state machines and address counters
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        state[b] <= EMPTY;
        count[b] <= '0;
      end
      oldest  <= 1'b0;
      wr_bank <= 1'b0;
      wr_ptr  <= '0;
      rd_addr <= '0;
    end else begin
      if (wr.wr_stb) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd.rd_stb) begin
        rd_addr <= rd_addr + 1'b1;
      end
      for (int b = 0; b < NUM_BANKS; b++) begin
        case (state[b])
          EMPTY: begin
            // Writer claims the bank and the write address restarts
            if (wr.wr_act[b]) begin
              state[b] <= WRITING;
              wr_bank  <= 1'(b);
              wr_ptr   <= '0;
            end
          end
          WRITING: begin
            if (!wr.wr_act[b]) begin
              count[b] <= wr_fill;
              if (wr_fill == '0) begin
                // Nothing written so the bank goes straight back
                state[b] <= EMPTY;
              end else begin
                state[b] <= FULL;
                // Next out unless the other bank still holds data
                if (state[b ^ 1] != FULL && state[b ^ 1] != READING) begin
                  oldest <= 1'(b);
                end
              end
            end
          end
          FULL: begin
            // A strobe on the claiming edge already takes word 0
            if (rd.rd_act && (oldest == 1'(b))) begin
              state[b] <= READING;
              rd_addr  <= CW'(rd.rd_stb);
            end
          end
          READING: begin
            // Released so the other bank is next in line
            if (!rd.rd_act) begin
              state[b] <= EMPTY;
              oldest   <= ~1'(b);
            end
          end
          default: begin
            state[b] <= EMPTY;
          end
        endcase
      end
    end
  end

  // Write port
  always_ff @(posedge clk) begin
    if (wr.wr_stb) begin
      mem[wr_bank][wr_ptr[AW-1:0]] <= wr.wr_data;
    end
  end

  // Read port with one cycle of latency
  always_ff @(posedge clk) begin
    if (rd.rd_stb) begin
      rd.rd_data <= mem[oldest][rd_ptr[AW-1:0]];
    end
  end

endmodule

//--- src/axis_to_block_writer.sv
/*
  Stream producer for the ping-pong buffer.
  Grabs an empty bank, writes accepted beats, closes the block at last or when full.
*/
module axis_to_block_writer #(
  parameter int DATA_WIDTH = ppfifo_cfg_pkg::DATA_WIDTH_DEF,
  parameter int DEPTH      = ppfifo_cfg_pkg::DEPTH_DEF
) (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  i_s_valid,
  input  logic [DATA_WIDTH-1:0] i_s_data,
  input  logic                  i_s_last,
  output logic                  o_s_ready,
  block_fifo_if.writer          bus
);
  import ppfifo_cfg_pkg::*;
  import ppfifo_block_pkg::*;

  localparam int CW = count_width(DEPTH);

  typedef enum logic [1:0] {
    S_IDLE    = 2'd0,
    S_ACTIVE  = 2'd1,
    S_RELEASE = 2'd2
  } wr_state_t;

  wr_state_t     state;
  logic [CW-1:0] count;
  bank_sel_t     grab;
  logic          accept;
  logic          close_blk;

  // Lower-numbered empty bank wins
  assign grab = bus.wr_rdy[0] ? 2'b01 : 2'b10;

  // Room left in the claimed bank
  assign o_s_ready = (|bus.wr_act) && (count < bus.wr_size);
  assign accept    = i_s_valid && o_s_ready;

  // Last only counts when the beat is taken
  assign close_blk = accept && (i_s_last || (count == bus.wr_size - 1'b1));

  always_ff @(posedge clk) begin
    if (rst) begin
      state      <= S_IDLE;
      count      <= '0;
      bus.wr_act <= '0;
      bus.wr_stb <= 1'b0;
    end else begin
      // One strobe per accepted beat, a cycle later
      bus.wr_stb <= accept;
      case (state)
        S_IDLE: begin
          if ((|bus.wr_rdy) && !(|bus.wr_act)) begin
            bus.wr_act <= grab;
            count      <= '0;
            state      <= S_ACTIVE;
          end
        end
        S_ACTIVE: begin
          if (accept) begin
            count <= count + 1'b1;
          end
          // Final strobe lands while act is already low
          if (close_blk) begin
            bus.wr_act <= '0;
            state      <= S_RELEASE;
          end
        end
        S_RELEASE: begin
          // Give the buffer one edge to mark the bank full
          state <= S_IDLE;
        end
        default: begin
          state <= S_IDLE;
        end
      endcase
    end
  end

  // Word register behind the strobe
  always_ff @(posedge clk) begin
    if (accept) begin
      bus.wr_data <= i_s_data;
    end
  end

endmodule

//--- src/block_fifo_if.sv
/*
  Ping-pong block FIFO handshake, write side and read side.
  One instance serves the writer, another the reader.
*/
interface block_fifo_if #(
  parameter int DATA_WIDTH = ppfifo_cfg_pkg::DATA_WIDTH_DEF,
  parameter int DEPTH      = ppfifo_cfg_pkg::DEPTH_DEF
);
  import ppfifo_cfg_pkg::*;
  import ppfifo_block_pkg::*;

  localparam int CW = count_width(DEPTH);

  // Write side, one rdy bit per empty bank
  bank_sel_t             wr_rdy;
  bank_sel_t             wr_act;
  logic [CW-1:0]         wr_size;
  logic                  wr_stb;
  logic [DATA_WIDTH-1:0] wr_data;

  // Read side, always the oldest full bank
  logic                  rd_rdy;
  logic                  rd_act;
  logic [CW-1:0]         rd_size;
  logic                  rd_stb;
  logic [DATA_WIDTH-1:0] rd_data;

  // Producer view
  modport writer (input wr_rdy, input wr_size, output wr_act, output wr_stb, output wr_data);

  // Buffer view of the write side
  modport wbuf (output wr_rdy, output wr_size, input wr_act, input wr_stb, input wr_data);

  // Consumer view
  modport reader (input rd_rdy, input rd_size, input rd_data, output rd_act, output rd_stb);

  // Buffer view of the read side
  modport rbuf (output rd_rdy, output rd_size, output rd_data, input rd_act, input rd_stb);

endinterface

//--- src/ppfifo_block_pkg.sv
/*
  Bank select and bank state types of the two-bank block FIFO.
  Shared by the buffer and the block FIFO interface.
*/
package ppfifo_block_pkg;

  // Number of banks in the ping-pong buffer
  localparam int NUM_BANKS = 2;

  // One-hot bank pair, bit n stands for bank n
  typedef logic [NUM_BANKS-1:0] bank_sel_t;

  // Life cycle of one bank
  typedef enum logic [1:0] {
    EMPTY   = 2'd0,
    WRITING = 2'd1,
    FULL    = 2'd2,
    READING = 2'd3
  } bank_state_t;

endpackage

//--- src/ppfifo_cfg_pkg.sv
/*
  Sizing constants for the stream ping-pong buffer.
  Modules take their defaults from here and derive counter widths.
*/
package ppfifo_cfg_pkg;

  // Stream word width
  localparam int DATA_WIDTH_DEF = 32;

  // Words per bank
  localparam int DEPTH_DEF = 16;

  // Counter width able to hold the value depth itself
  function automatic int count_width(input int depth);
    return $clog2(depth) + 1;
  endfunction

endpackage
